//--- rtl/pcs_pkg.sv
package pcs_pkg;

	localparam int xgmii_data_width = 64;
	localparam int xgmii_ctrl_width = 8;
	localparam int coded_block_width = 66;
	localparam int scrambler_width = 58;
	localparam int cfg_addr_width = 2;
	localparam int cfg_data_width = 32;

	typedef enum logic [3:0] {
		kind_data,
		kind_idle,
		kind_start0,
		kind_term0,
		kind_term1,
		kind_term2,
		kind_term3,
		kind_term4,
		kind_term5,
		kind_term6,
		kind_term7,
		kind_error
	} block_kind_t;

	typedef logic [coded_block_width-1:0] coded_block_t;

	localparam logic [1:0] sync_data = 2'b01;
	localparam logic [1:0] sync_ctrl = 2'b10;

	// Idle and error share one block type field value
	localparam logic [7:0] type_idle = 8'h1E;
	localparam logic [7:0] type_start0 = 8'h78;
	// Element K is the type byte for a terminate in lane K
	localparam logic [7:0][7:0] type_term = {
		8'hFF, 8'hE1, 8'hD2, 8'hCC, 8'hB4, 8'hAA, 8'h99, 8'h87
	};

	localparam logic [7:0] char_idle = 8'h07;
	localparam logic [7:0] char_start = 8'hFB;
	localparam logic [7:0] char_term = 8'hFD;
	localparam logic [7:0] char_error = 8'hFE;

	localparam logic [6:0] code_idle = 7'h00;
	localparam logic [6:0] code_error = 7'h1E;

	localparam logic [scrambler_width-1:0] scrambler_seed = {scrambler_width{1'b1}};

	localparam logic [cfg_addr_width-1:0] reg_control = 2'd0;
	localparam logic [cfg_addr_width-1:0] reg_block_count = 2'd1;
	localparam logic [cfg_addr_width-1:0] reg_error_count = 2'd2;

endpackage

//--- rtl/block_type_classifier.sv
`timescale 1ns/1ps

module block_type_classifier
	import pcs_pkg::*;
(
	input  logic                        tb_clock,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [xgmii_ctrl_width-1:0] tx_ctrl,
	input  logic [xgmii_data_width-1:0] tx_data,
	output block_kind_t                 kind,
	output logic                        kind_valid,
	output logic [xgmii_ctrl_width-1:0] held_ctrl,
	output logic [xgmii_data_width-1:0] held_data
);

	block_kind_t next_kind;

	// Lane 0 sits in the top byte
	function automatic logic [7:0] lane_byte(input logic [xgmii_data_width-1:0] data, input int lane);
		return data[xgmii_data_width-1-8*lane -: 8];
	endfunction

	// Terminate in the given lane with idles after it
	function automatic logic term_at(input logic [xgmii_data_width-1:0] data, input int lane);
		logic ok;
		ok = (lane_byte(data, lane) == char_term);
		for (int i = lane + 1; i < 8; i++) begin
			ok = ok && (lane_byte(data, i) == char_idle);
		end
		return ok;
	endfunction

	always_comb begin
		next_kind = kind_error;
		if (tx_ctrl == 8'h00) begin
			next_kind = kind_data;
		end else if (tx_ctrl == 8'hFF && tx_data == {8{char_idle}}) begin
			next_kind = kind_idle;
		end else if (tx_ctrl == 8'h80 && lane_byte(tx_data, 0) == char_start) begin
			next_kind = kind_start0;
		end else begin
			// Mask for termK covers lanes K to 7
			for (int k = 0; k < 8; k++) begin
				if (tx_ctrl == (8'hFF >> k) && term_at(tx_data, k)) begin
					next_kind = block_kind_t'(kind_term0 + 4'(k));
				end
			end
		end
	end

	always_ff @(posedge tb_clock) begin
		if (rst) begin
			kind_valid <= 1'b0;
		end else begin
			kind_valid <= in_valid;
		end
	end

	always_ff @(posedge tb_clock) begin
		if (in_valid) begin
			kind <= next_kind;
			held_ctrl <= tx_ctrl;
			held_data <= tx_data;
		end
	end

endmodule

//--- rtl/block_encoder.sv
`timescale 1ns/1ps

module block_encoder
	import pcs_pkg::*;
(
	input  logic                        tb_clock,
	input  logic                        rst,
	input  block_kind_t                 kind,
	input  logic                        kind_valid,
	input  logic [xgmii_ctrl_width-1:0] held_ctrl,
	input  logic [xgmii_data_width-1:0] held_data,
	output coded_block_t                block,
	output logic                        block_valid,
	output logic                        block_is_error
);

	logic [55:0] body;
	logic [2:0] term_lane;
	coded_block_t next_block;

	function automatic logic [6:0] lane_code(input logic is_ctrl, input logic [7:0] ch);
		if (is_ctrl && ch == char_idle) begin
			return code_idle;
		end
		return code_error;
	endfunction

	always_comb begin
		body = '0;
		term_lane = 3'(kind - kind_term0);
		next_block = '0;
		case (kind)
			kind_data: begin
				next_block = {sync_data, held_data};
			end
			kind_idle: begin
				for (int i = 0; i < 8; i++) begin
					body[7*(7-i) +: 7] = lane_code(held_ctrl[7-i], held_data[63-8*i -: 8]);
				end
				next_block = {sync_ctrl, type_idle, body};
			end
			kind_error: begin
				body = {8{code_error}};
				next_block = {sync_ctrl, type_idle, body};
			end
			kind_start0: begin
				next_block = {sync_ctrl, type_start0, held_data[55:0]};
			end
			default: begin
				// Data lanes first, then 7-K pad bits, then codes for the trailing lanes
				for (int i = 0; i < 7; i++) begin
					if (i < int'(term_lane)) begin
						body[55-8*i -: 8] = held_data[63-8*i -: 8];
					end
				end
				for (int i = 1; i < 8; i++) begin
					if (i > int'(term_lane)) begin
						body[7*(7-i) +: 7] = lane_code(held_ctrl[7-i], held_data[63-8*i -: 8]);
					end
				end
				next_block = {sync_ctrl, type_term[term_lane], body};
			end
		endcase
	end

	always_ff @(posedge tb_clock) begin
		if (rst) begin
			block_valid <= 1'b0;
			block_is_error <= 1'b0;
		end else begin
			block_valid <= kind_valid;
			block_is_error <= kind_valid && (kind == kind_error);
		end
	end

	always_ff @(posedge tb_clock) begin
		if (kind_valid) begin
			block <= next_block;
		end
	end

endmodule

//--- rtl/scrambler.sv
`timescale 1ns/1ps

module scrambler
	import pcs_pkg::*;
(
	input  logic         tb_clock,
	input  logic         rst,
	input  logic         bypass,
	input  coded_block_t block,
	input  logic         block_valid,
	output coded_block_t scr_block,
	output logic         scr_valid
);

	logic [scrambler_width-1:0] state;
	logic [scrambler_width-1:0] next_state;
	logic [63:0] payload;

	// Polynomial x^58 + x^39 + 1 with the payload MSB going first
	always_comb begin
		next_state = state;
		payload = block[63:0];
		if (!bypass) begin
			for (int i = 63; i >= 0; i--) begin
				payload[i] = block[i] ^ next_state[38] ^ next_state[57];
				next_state = {next_state[scrambler_width-2:0], payload[i]};
			end
		end
	end

	always_ff @(posedge tb_clock) begin
		if (rst) begin
			state <= scrambler_seed;
			scr_valid <= 1'b0;
		end else begin
			scr_valid <= block_valid;
			if (block_valid && !bypass) begin
				state <= next_state;
			end
		end
	end

	always_ff @(posedge tb_clock) begin
		if (block_valid) begin
			scr_block <= {block[coded_block_width-1:64], payload};
		end
	end

endmodule

//--- rtl/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo
	import pcs_pkg::*;
#(
	parameter type payload_t = coded_block_t,
	parameter int fifo_depth = 8,
	parameter int credit_width = 4
) (
	input  logic     tb_clock,
	input  logic     rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     out_credit,
	output payload_t pop_data,
	output logic     out_valid,
	output logic     in_credit
);

	localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	payload_t mem [fifo_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [credit_width-1:0] count;
	logic [credit_width-1:0] credits;
	logic pop;

	function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
		return (ptr == ptr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop = (count != '0) && (credits != '0);

	always_ff @(posedge tb_clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= '0;
			out_valid <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			out_valid <= pop;
			in_credit <= pop;
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Grants beyond the counter range saturate
			case ({out_credit, pop})
				2'b10: credits <= (credits == '1) ? credits : credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge tb_clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

endmodule

//--- rtl/pcs_config_regs.sv
`timescale 1ns/1ps

module pcs_config_regs
	import pcs_pkg::*;
(
	input  logic                      tb_clock,
	input  logic                      rst,
	input  logic                      cfg_write,
	input  logic [cfg_addr_width-1:0] cfg_addr,
	input  logic [cfg_data_width-1:0] cfg_wdata,
	input  logic                      count_block,
	input  logic                      count_error,
	output logic [cfg_data_width-1:0] cfg_rdata,
	output logic                      bypass
);

	logic [cfg_data_width-1:0] block_count;
	logic [cfg_data_width-1:0] error_count;

	always_ff @(posedge tb_clock) begin
		if (rst) begin
			bypass <= 1'b0;
			block_count <= '0;
			error_count <= '0;
		end else begin
			if (cfg_write && cfg_addr == reg_control) begin
				bypass <= cfg_wdata[0];
			end
			// Clear wins over a same-cycle count
			if (cfg_write && cfg_addr == reg_block_count) begin
				block_count <= '0;
			end else if (count_block && block_count != '1) begin
				block_count <= block_count + 1'b1;
			end
			if (cfg_write && cfg_addr == reg_error_count) begin
				error_count <= '0;
			end else if (count_error && error_count != '1) begin
				error_count <= error_count + 1'b1;
			end
		end
	end

	always_comb begin
		case (cfg_addr)
			reg_control: cfg_rdata = {{(cfg_data_width-1){1'b0}}, bypass};
			reg_block_count: cfg_rdata = block_count;
			reg_error_count: cfg_rdata = error_count;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

//--- rtl/pcs_tx_top.sv
`timescale 1ns/1ps

module pcs_tx_top
	import pcs_pkg::*;
#(
	parameter int fifo_depth = 8
) (
	input  logic                        tb_clock,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [xgmii_ctrl_width-1:0] tx_ctrl,
	input  logic [xgmii_data_width-1:0] tx_data,
	input  logic                        out_credit,
	input  logic                        cfg_write,
	input  logic [cfg_addr_width-1:0]   cfg_addr,
	input  logic [cfg_data_width-1:0]   cfg_wdata,
	output logic                        in_credit,
	output coded_block_t                out_block,
	output logic                        out_valid,
	output logic [cfg_data_width-1:0]   cfg_rdata
);

	localparam int credit_width = $clog2(fifo_depth + 1);

	block_kind_t kind;
	logic kind_valid;
	logic [xgmii_ctrl_width-1:0] held_ctrl;
	logic [xgmii_data_width-1:0] held_data;
	coded_block_t block;
	logic block_valid;
	logic block_is_error;
	coded_block_t scr_block;
	logic scr_valid;
	logic bypass;

	block_type_classifier block_type_classifier_i (
		.tb_clock   (tb_clock),
		.rst        (rst),
		.in_valid   (in_valid),
		.tx_ctrl    (tx_ctrl),
		.tx_data    (tx_data),
		.kind       (kind),
		.kind_valid (kind_valid),
		.held_ctrl  (held_ctrl),
		.held_data  (held_data)
	);

	block_encoder block_encoder_i (
		.tb_clock       (tb_clock),
		.rst            (rst),
		.kind           (kind),
		.kind_valid     (kind_valid),
		.held_ctrl      (held_ctrl),
		.held_data      (held_data),
		.block          (block),
		.block_valid    (block_valid),
		.block_is_error (block_is_error)
	);

	scrambler scrambler_i (
		.tb_clock    (tb_clock),
		.rst         (rst),
		.bypass      (bypass),
		.block       (block),
		.block_valid (block_valid),
		.scr_block   (scr_block),
		.scr_valid   (scr_valid)
	);

	credit_fifo #(
		.payload_t    (coded_block_t),
		.fifo_depth   (fifo_depth),
		.credit_width (credit_width)
	) credit_fifo_i (
		.tb_clock   (tb_clock),
		.rst        (rst),
		.push       (scr_valid),
		.push_data  (scr_block),
		.out_credit (out_credit),
		.pop_data   (out_block),
		.out_valid  (out_valid),
		.in_credit  (in_credit)
	);

	// Counters tap the encoder output
	pcs_config_regs pcs_config_regs_i (
		.tb_clock    (tb_clock),
		.rst         (rst),
		.cfg_write   (cfg_write),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.count_block (block_valid),
		.count_error (block_is_error),
		.cfg_rdata   (cfg_rdata),
		.bypass      (bypass)
	);

endmodule

//--- testbench/tb_pcs_tx_ref.svh
`ifndef TB_PCS_TX_REF_SVH
`define TB_PCS_TX_REF_SVH

// Type byte for a terminate in lane K
localparam logic [7:0] term_types [8] = '{
	8'h87, 8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF
};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

// Lane 0 is the top byte
function automatic logic [7:0] lane_of(input logic [63:0] word, input int lane);
	return word[63-8*lane -: 8];
endfunction

// Lane L pairs with control bit 7-L
function automatic block_kind_t classify_word(input logic [7:0] ctrl, input logic [63:0] word);
	logic ok;
	if (ctrl == 8'h00)
		return kind_data;
	if (ctrl == 8'hFF && word == {8{char_idle}})
		return kind_idle;
	if (ctrl == 8'h80 && lane_of(word, 0) == char_start)
		return kind_start0;
	for (int k = 0; k < 8; k++) begin
		ok = (ctrl == (8'hFF >> k)) && (lane_of(word, k) == char_term);
		for (int l = k + 1; l < 8; l++)
			ok = ok && (lane_of(word, l) == char_idle);
		if (ok)
			return block_kind_t'(int'(kind_term0) + k);
	end
	return kind_error;
endfunction

function automatic coded_block_t encode_block(input block_kind_t kind, input logic [63:0] word);
	logic [55:0] body;
	coded_block_t blk;
	int k;
	body = '0;
	k = int'(kind) - int'(kind_term0);
	case (kind)
		kind_data: blk = {sync_data, word};
		kind_idle: blk = {sync_ctrl, 8'h1E, {8{code_idle}}};
		kind_error: blk = {sync_ctrl, 8'h1E, {8{code_error}}};
		kind_start0: blk = {sync_ctrl, 8'h78, word[55:0]};
		default: begin
			// Data bytes from the top, then pad, then one code per idle lane
			for (int l = 0; l < k; l++)
				body[55-8*l -: 8] = lane_of(word, l);
			for (int l = k + 1; l < 8; l++)
				body[7*(7-l) +: 7] = code_idle;
			blk = {sync_ctrl, term_types[k], body};
		end
	endcase
	return blk;
endfunction

// Payload scrambled MSB first with x^58 + x^39 + 1
function automatic coded_block_t scramble_payload(input coded_block_t blk,
		input logic [57:0] state_in, output logic [57:0] state_out);
	coded_block_t res;
	logic [57:0] s;
	res = blk;
	s = state_in;
	for (int i = 63; i >= 0; i--) begin
		res[i] = blk[i] ^ s[38] ^ s[57];
		s = {s[56:0], res[i]};
	end
	state_out = s;
	return res;
endfunction

`endif

//--- testbench/tb_pcs_tx.sv
`timescale 1ns/1ps

module tb_pcs_tx
	import pcs_pkg::*;
();

	localparam int fifo_depth = 8;
	// Word counts of the test phases in order
	localparam int total_words = 40 + 11 + 4 + 20 + 40;
	localparam int cycle_limit = 10 * total_words + 200;

	logic tb_clock;
	logic rst;
	logic in_valid;
	logic [xgmii_ctrl_width-1:0] tx_ctrl;
	logic [xgmii_data_width-1:0] tx_data;
	logic out_credit = 1'b0;
	logic cfg_write;
	logic [cfg_addr_width-1:0] cfg_addr;
	logic [cfg_data_width-1:0] cfg_wdata;
	logic in_credit;
	coded_block_t out_block;
	logic out_valid;
	logic [cfg_data_width-1:0] cfg_rdata;

	coded_block_t exp_q[$];
	string name_q[$];
	coded_block_t exp_block;
	string exp_name;
	logic [57:0] model_state = scrambler_seed;
	logic [57:0] next_state;
	logic model_bypass = 1'b0;
	logic [31:0] main_rng = 32'h1059_9328;
	logic [31:0] credit_rng = 32'h1059_9328;
	logic [63:0] word;
	int credit_mode = 1;
	int error_count = 0;
	int src_credits = fifo_depth;
	int sent_words = 0;
	int sent_errors = 0;
	int granted = 0;
	int popped = 0;
	int cycle_count = 0;

	`include "tb_pcs_tx_ref.svh"

	pcs_tx_top #(.fifo_depth(fifo_depth)) pcs_tx_top_i (.*);

	initial begin
		tb_clock = 1'b0;
		forever #5 tb_clock = ~tb_clock;
	end

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		main_rng = xorshift32(main_rng);
		hi = main_rng;
		main_rng = xorshift32(main_rng);
		return {hi, main_rng};
	endfunction

	// Credits returned by the FIFO are collected at each edge
	task automatic next_cycle();
		@(posedge tb_clock);
		if (in_credit)
			src_credits++;
		in_valid <= 1'b0;
		cfg_write <= 1'b0;
	endtask

	task automatic send_word(input logic [7:0] ctrl, input logic [63:0] data, input string name);
		block_kind_t kind;
		coded_block_t blk;
		do
			next_cycle();
		while (src_credits == 0);
		in_valid <= 1'b1;
		tx_ctrl <= ctrl;
		tx_data <= data;
		src_credits--;
		sent_words++;
		kind = classify_word(ctrl, data);
		if (kind == kind_error)
			sent_errors++;
		blk = encode_block(kind, data);
		if (!model_bypass) begin
			blk = scramble_payload(blk, model_state, next_state);
			model_state = next_state;
		end
		exp_q.push_back(blk);
		name_q.push_back(name);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			next_cycle();
		repeat (3)
			next_cycle();
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		next_cycle();
		cfg_write <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		next_cycle();
	endtask

	task automatic check_reg(input string name, input logic [1:0] addr, input logic [31:0] expected);
		next_cycle();
		cfg_addr <= addr;
		next_cycle();
		if (cfg_rdata !== expected) begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, cfg_rdata);
			error_count++;
		end
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		tx_ctrl = '0;
		tx_data = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (5) @(posedge tb_clock);
		rst <= 1'b0;
		for (int i = 0; i < 40; i++)
			send_word(8'h00, rand64(), "random_data");
		drain();
		send_word(8'hFF, {8{char_idle}}, "idle");
		for (int i = 0; i < 2; i++)
			send_word(8'h80, {char_start, 56'(rand64())}, "start0");
		for (int k = 0; k < 8; k++) begin
			word = rand64();
			for (int l = k; l < 8; l++)
				word[63-8*l -: 8] = (l == k) ? char_term : char_idle;
			send_word(8'hFF >> k, word, "terminate");
		end
		drain();
		send_word(8'hFF, 64'h0707_07AB_0707_0707, "bad_ctrl_byte");
		send_word(8'h08, 64'h0101_0101_FB02_0202, "start_lane4");
		send_word(8'h1F, 64'h0A0B_0CFD_0707_3C07, "data_after_term");
		send_word(8'hFF, {8{char_error}}, "error_chars");
		drain();
		write_reg(reg_control, 32'd1);
		model_bypass = 1'b1;
		check_reg("bypass_read", reg_control, 32'd1);
		for (int i = 0; i < 10; i++)
			send_word(8'h00, rand64(), "bypass");
		drain();
		write_reg(reg_control, 32'd0);
		model_bypass = 1'b0;
		for (int i = 0; i < 10; i++)
			send_word(8'h00, rand64(), "scramble_resume");
		drain();
		// Leftover grants pass the first eight words and the rest wait in the FIFO
		credit_mode <= 0;
		for (int i = 0; i < 16; i++)
			send_word(8'h00, rand64(), "credit_hold");
		repeat (60)
			next_cycle();
		if (exp_q.size() != fifo_depth || src_credits != 0) begin
			$display("ERROR credit_hold: expected %0d waiting and 0 credits, actual %0d and %0d",
				fifo_depth, exp_q.size(), src_credits);
			error_count++;
		end
		credit_mode <= 2;
		for (int i = 0; i < 24; i++)
			send_word(8'h00, rand64(), "credit_random");
		drain();
		check_reg("block_count", reg_block_count, 32'(sent_words));
		check_reg("error_count", reg_error_count, 32'(sent_errors));
		if (src_credits != fifo_depth) begin
			$display("ERROR credit_return: expected %0d, actual %0d", fifo_depth, src_credits);
			error_count++;
		end
		write_reg(reg_block_count, 32'hA5A5_0001);
		write_reg(reg_error_count, 32'hFFFF_FFFF);
		check_reg("block_count_clear", reg_block_count, 32'd0);
		check_reg("error_count_clear", reg_error_count, 32'd0);
		$display("Summary: %0d errors, %0d words sent, %0d blocks received",
			error_count, sent_words, popped);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Downstream sink that checks each block and grants output credits
	always @(posedge tb_clock) begin
		out_credit <= 1'b0;
		credit_rng = xorshift32(credit_rng);
		if (!rst) begin
			if (out_credit)
				granted++;
			if (out_valid) begin
				popped++;
				if (popped > granted) begin
					$display("ERROR block %0d left with only %0d credits granted", popped, granted);
					error_count++;
				end
				if (exp_q.size() == 0) begin
					$display("ERROR block %h came out with no word sent for it", out_block);
					error_count++;
				end else begin
					exp_block = exp_q.pop_front();
					exp_name = name_q.pop_front();
					if (out_block !== exp_block) begin
						$display("ERROR %s: expected %h, actual %h", exp_name, exp_block, out_block);
						error_count++;
					end
				end
			end
			// Mode 1 grants steadily and mode 2 grants at random
			if (granted - popped < fifo_depth && (credit_mode == 1 ||
					(credit_mode == 2 && credit_rng[1:0] == 2'b00)))
				out_credit <= 1'b1;
		end
	end

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge tb_clock);
			cycle_count++;
		end
		$display("ERROR run timed out after %0d cycles with %0d errors and %0d blocks missing",
			cycle_count, error_count, exp_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- list.f
rtl/pcs_pkg.sv
rtl/block_type_classifier.sv
rtl/block_encoder.sv
rtl/scrambler.sv
rtl/credit_fifo.sv
rtl/pcs_config_regs.sv
rtl/pcs_tx_top.sv
+incdir+testbench
testbench/tb_pcs_tx.sv

//--- run.sh
#!/bin/sh
# Build and run the PCS transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_pcs_tx -o tb_pcs_tx
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pcs_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0
